/* backend_top.sv */
`timescale 1ns/1ps
`default_nettype none

module backend_top import core_pkg::*; #(
	parameter int DATA_W = 32
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [1:0][31:0]       inst_word_i,
	input  logic [1:0]             inst_valid_i,
	input  logic                   stall_i,
	output logic [1:0]             accept_o,
	output wb_ctrl_t [1:0]         wb_ctrl_o,
	output logic [1:0][DATA_W-1:0] wb_data_o
);

	dec_inst_t [1:0] dec;
	issue_slot_t [1:0] slot;
	logic [3:0][DATA_W-1:0] rdata;
	wb_ctrl_t [1:0][2:0] stage_ctrl;
	logic [1:0][2:0][DATA_W-1:0] stage_data;

	for (genvar i = 0; i < 2; i++) begin : g_dec
		inst_decode u_dec (
			.inst_word_i (inst_word_i[i]),
			.valid_i     (inst_valid_i[i]),
			.dec_o       (dec[i])
		);
	end

	issue_ctrl u_issue (
		.clk      (clk),
		.rst_n    (rst_n),
		.dec_i    (dec),
		.valid_i  (inst_valid_i),
		.stall_i  (stall_i),
		.accept_o (accept_o),
		.slot_o   (slot)
	);

	// read ports 0..1 feed pipe 0, ports 2..3 feed pipe 1
	regfile #(.DATA_W(DATA_W)) u_rf (
		.clk       (clk),
		.rst_n     (rst_n),
		.raddr_i   ({slot[1].inst.r_reg, slot[0].inst.r_reg}),
		.rdata_o   (rdata),
		.wb_ctrl_i (wb_ctrl_o),
		.wb_data_i (wb_data_o)
	);

	for (genvar i = 0; i < 2; i++) begin : g_pipe
		exec_pipe #(
			.DATA_W       (DATA_W),
			.PIPE_HAS_MUL (i == 0)
		) u_pipe (
			.clk         (clk),
			.rst_n       (rst_n),
			.stall_i     (stall_i),
			.slot_i      (slot[i]),
			.opnd_i      (rdata[2*i+1:2*i]),
			.peer_ctrl_i (stage_ctrl[1-i]),
			.peer_data_i (stage_data[1-i]),
			.own_ctrl_o  (stage_ctrl[i]),
			.own_data_o  (stage_data[i]),
			.wb_ctrl_o   (wb_ctrl_o[i]),
			.wb_data_o   (wb_data_o[i])
		);
	end

endmodule

`default_nettype wire

/* core_pkg.sv */
`default_nettype none

package core_pkg;

	// opcode field, bits 31..26 of the instruction word
	typedef enum logic [5:0] {
		OP_NOP  = 6'h00,
		OP_ADD  = 6'h01,
		OP_SUB  = 6'h02,
		OP_AND  = 6'h03,
		OP_XOR  = 6'h04,
		OP_ADDI = 6'h05,
		OP_MUL  = 6'h06
	} op_e;

	// bit positions in the one-hot forwarding source
	localparam int FWD_RF = 0;
	localparam int FWD_M1 = 1;
	localparam int FWD_M2 = 2;
	localparam int FWD_WB = 3;

	// register-register format, rd = rj op rk
	typedef struct packed {
		logic [10:0] pad;
		logic [4:0]  rk;
		logic [4:0]  rj;
		logic [4:0]  rd;
	} r_body_t;

	// immediate format, rd = rj op imm
	typedef struct packed {
		logic [3:0]  pad;
		logic [11:0] imm;
		logic [4:0]  rj;
		logic [4:0]  rd;
	} i_body_t;

	typedef union packed {
		r_body_t r;
		i_body_t i;
	} inst_body_u;

	typedef struct packed {
		op_e             op;
		// r_reg[0] is rk, r_reg[1] is rj
		logic [1:0][4:0] r_reg;
		logic [4:0]      w_reg;
		logic [11:0]     imm;
		logic            use_imm;
		// result only after m2
		logic            slow;
		logic            pipe0_only;
	} dec_inst_t;

	typedef struct packed {
		logic [3:0] src;
		logic       pipe;
	} fwd_src_t;

	typedef struct packed {
		logic                valid;
		dec_inst_t           inst;
		fwd_src_t [1:0]      fwd;
	} issue_slot_t;

	typedef struct packed {
		logic       valid;
		logic [4:0] w_reg;
	} wb_ctrl_t;

endpackage

`default_nettype wire

/* exec_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_pipe import core_pkg::*; #(
	parameter int DATA_W       = 32,
	parameter bit PIPE_HAS_MUL = 1'b1
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   stall_i,
	input  issue_slot_t            slot_i,
	input  logic [1:0][DATA_W-1:0] opnd_i,
	input  wb_ctrl_t [2:0]         peer_ctrl_i,
	input  logic [2:0][DATA_W-1:0] peer_data_i,
	output wb_ctrl_t [2:0]         own_ctrl_o,
	output logic [2:0][DATA_W-1:0] own_data_o,
	output wb_ctrl_t               wb_ctrl_o,
	output logic [DATA_W-1:0]      wb_data_o
);

	localparam int LO_W = DATA_W / 2;
	localparam int HI_W = DATA_W - LO_W;
	// the pipe with the multiplier is pipe 0
	localparam bit OWN_PIPE = !PIPE_HAS_MUL;

	issue_slot_t ex_slot_q;
	logic [1:0][DATA_W-1:0] ex_opnd_q;
	wb_ctrl_t [1:0][2:0] src_ctrl;
	logic [1:0][2:0][DATA_W-1:0] src_data;
	wb_ctrl_t [1:0] opnd_ctrl;
	logic [1:0][DATA_W-1:0] opnd;
	logic [DATA_W-1:0] alu_a;
	logic [DATA_W-1:0] alu_b;
	logic [DATA_W-1:0] alu_res;
	wb_ctrl_t ex_ctrl;
	logic ex_mul;

	wb_ctrl_t m1_ctrl_q;
	logic m1_mul_q;
	logic [DATA_W-1:0] m1_res_q;
	logic [DATA_W-1:0] m1_a_q;
	logic [DATA_W-1:0] m1_b_q;
	logic [DATA_W-1:0] m1_pll;
	logic [HI_W-1:0] m1_pcr;

	wb_ctrl_t m2_ctrl_q;
	logic m2_mul_q;
	logic [DATA_W-1:0] m2_res_q;
	logic [DATA_W-1:0] m2_pll_q;
	logic [HI_W-1:0] m2_pcr_q;
	logic [DATA_W-1:0] m2_result;

	wb_ctrl_t wb_ctrl_q;
	logic [DATA_W-1:0] wb_res_q;

	// operand select: register file or a named stage of either pipe
	always_comb begin
		for (int j = 0; j < 2; j++) begin
			if (ex_slot_q.fwd[j].pipe == OWN_PIPE) begin
				src_ctrl[j] = own_ctrl_o;
				src_data[j] = own_data_o;
			end else begin
				src_ctrl[j] = peer_ctrl_i;
				src_data[j] = peer_data_i;
			end
			opnd_ctrl[j] = '0;
			opnd[j] = ex_opnd_q[j];
			if (ex_slot_q.fwd[j].src[FWD_M1]) begin
				opnd_ctrl[j] = src_ctrl[j][0];
				opnd[j] = src_data[j][0];
			end else if (ex_slot_q.fwd[j].src[FWD_M2]) begin
				opnd_ctrl[j] = src_ctrl[j][1];
				opnd[j] = src_data[j][1];
			end else if (ex_slot_q.fwd[j].src[FWD_WB]) begin
				opnd_ctrl[j] = src_ctrl[j][2];
				opnd[j] = src_data[j][2];
			end
		end
	end

	// rj is operand 1, rk or the immediate is operand 0
	assign alu_a = opnd[1];
	assign alu_b = ex_slot_q.inst.use_imm ? DATA_W'($signed(ex_slot_q.inst.imm)) : opnd[0];

	always_comb begin
		case (ex_slot_q.inst.op)
			OP_ADD, OP_ADDI: alu_res = alu_a + alu_b;
			OP_SUB: alu_res = alu_a - alu_b;
			OP_AND: alu_res = alu_a & alu_b;
			OP_XOR: alu_res = alu_a ^ alu_b;
			default: alu_res = '0;
		endcase
	end

	assign ex_ctrl.valid = ex_slot_q.valid && (ex_slot_q.inst.w_reg != 5'd0);
	assign ex_ctrl.w_reg = ex_slot_q.inst.w_reg;
	assign ex_mul = ex_slot_q.valid && ex_slot_q.inst.slow;

	if (PIPE_HAS_MUL) begin : g_mul
		// m1: low product and cross terms, m2 adds them up
		assign m1_pll = m1_a_q[LO_W-1:0] * m1_b_q[LO_W-1:0];
		assign m1_pcr = m1_a_q[DATA_W-1:LO_W] * m1_b_q[LO_W-1:0] +
			m1_a_q[LO_W-1:0] * m1_b_q[DATA_W-1:LO_W];
	end else begin : g_no_mul
		assign m1_pll = '0;
		assign m1_pcr = '0;
	end

	assign m2_result = m2_mul_q ? (m2_pll_q + {m2_pcr_q, {LO_W{1'b0}}}) : m2_res_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_slot_q <= '0;
			m1_ctrl_q <= '0;
			m1_mul_q <= 1'b0;
			m2_ctrl_q <= '0;
			m2_mul_q <= 1'b0;
			wb_ctrl_q <= '0;
		end else if (!stall_i) begin
			ex_slot_q <= slot_i;
			m1_ctrl_q <= ex_ctrl;
			m1_mul_q <= ex_mul;
			m2_ctrl_q <= m1_ctrl_q;
			m2_mul_q <= m1_mul_q;
			wb_ctrl_q <= m2_ctrl_q;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_i) begin
			ex_opnd_q <= opnd_i;
			m1_res_q <= alu_res;
			m1_a_q <= alu_a;
			m1_b_q <= alu_b;
			m2_res_q <= m1_res_q;
			m2_pll_q <= m1_pll;
			m2_pcr_q <= m1_pcr;
			wb_res_q <= m2_result;
		end
	end

	assign own_ctrl_o = {wb_ctrl_q, m2_ctrl_q, m1_ctrl_q};
	assign own_data_o = {wb_res_q, m2_result, m1_res_q};

	assign wb_ctrl_o.valid = m2_ctrl_q.valid & ~stall_i;
	assign wb_ctrl_o.w_reg = m2_ctrl_q.w_reg;
	assign wb_data_o = m2_result;

	// steering in the issue stage keeps mul off the pipe without a multiplier
	a_mul_pipe: assert property (@(posedge clk) disable iff (!rst_n)
		slot_i.valid && (slot_i.inst.op == OP_MUL) |-> PIPE_HAS_MUL);

	for (genvar j = 0; j < 2; j++) begin : g_fwd_chk
		// the stage picked by the scoreboard holds the producer of this operand
		a_fwd_match: assert property (@(posedge clk) disable iff (!rst_n)
			ex_slot_q.valid && !ex_slot_q.fwd[j].src[FWD_RF] |->
			opnd_ctrl[j].valid && (opnd_ctrl[j].w_reg == ex_slot_q.inst.r_reg[j]));
	end

endmodule

`default_nettype wire

/* files.f */
core_pkg.sv
inst_decode.sv
issue_ctrl.sv
regfile.sv
exec_pipe.sv
backend_top.sv
tb_checker.sv
tb_backend.sv

/* inst_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decode import core_pkg::*; (
	input  logic [31:0] inst_word_i,
	input  logic        valid_i,
	output dec_inst_t   dec_o
);

	logic [5:0] opcode;
	inst_body_u body;

	assign opcode = inst_word_i[31:26];
	assign body = inst_word_i[25:0];

	always_comb begin
		// invalid or unknown words fall through as nop
		dec_o = '0;
		dec_o.op = OP_NOP;
		if (valid_i) begin
			case (opcode)
				OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
					dec_o.op = op_e'(opcode);
					dec_o.r_reg[0] = body.r.rk;
					dec_o.r_reg[1] = body.r.rj;
					dec_o.w_reg = body.r.rd;
				end
				OP_ADDI: begin
					dec_o.op = OP_ADDI;
					dec_o.r_reg[1] = body.i.rj;
					dec_o.w_reg = body.i.rd;
					dec_o.imm = body.i.imm;
					dec_o.use_imm = 1'b1;
				end
				OP_MUL: begin
					dec_o.op = OP_MUL;
					dec_o.r_reg[0] = body.r.rk;
					dec_o.r_reg[1] = body.r.rj;
					dec_o.w_reg = body.r.rd;
					// only pipe 0 carries the multiplier
					dec_o.slow = 1'b1;
					dec_o.pipe0_only = 1'b1;
				end
				default: begin
					dec_o.op = OP_NOP;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* issue_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_ctrl import core_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  dec_inst_t [1:0]   dec_i,
	input  logic [1:0]        valid_i,
	input  logic              stall_i,
	output logic [1:0]        accept_o,
	output issue_slot_t [1:0] slot_o
);

	// pos shifts ex -> m1 -> m2 (left), rdy shifts the other way (right)
	typedef struct packed {
		logic       pipe;
		logic [2:0] pos;
		logic [2:0] rdy;
	} sb_entry_t;

	sb_entry_t [31:0] sb_q;
	logic [1:0] raw;
	logic [1:0] grant;
	logic [1:0] pipe_of;
	logic pair_dep;
	logic both_mul;
	logic revert;

	// producer in flight and not forwardable yet
	function automatic logic is_blocked(input sb_entry_t e);
		return (e.pos != 3'b000) && !e.rdy[0];
	endfunction

	// where the producer sits one cycle from now
	function automatic fwd_src_t fwd_of(input sb_entry_t e);
		fwd_src_t f;
		f.src[FWD_M1] = e.pos[0] & e.rdy[0];
		f.src[FWD_M2] = e.pos[1] & e.rdy[0];
		f.src[FWD_WB] = e.pos[2] & e.rdy[0];
		f.src[FWD_RF] = ~|f.src[FWD_WB:FWD_M1];
		f.pipe = e.pipe;
		return f;
	endfunction

	always_comb begin
		for (int k = 0; k < 2; k++) begin
			raw[k] = is_blocked(sb_q[dec_i[k].r_reg[0]]) | is_blocked(sb_q[dec_i[k].r_reg[1]]);
		end
	end

	// slot 1 must not touch what slot 0 writes
	assign pair_dep = (dec_i[0].w_reg != 5'd0) &&
		((dec_i[0].w_reg == dec_i[1].r_reg[0]) ||
		 (dec_i[0].w_reg == dec_i[1].r_reg[1]) ||
		 (dec_i[0].w_reg == dec_i[1].w_reg));
	assign both_mul = dec_i[0].pipe0_only & dec_i[1].pipe0_only;

	assign grant[0] = valid_i[0] & ~stall_i & ~raw[0];
	assign grant[1] = grant[0] & valid_i[1] & ~raw[1] & ~pair_dep & ~both_mul;
	assign accept_o = grant;

	// mul in slot 1 swaps the pair across the pipes
	assign revert = grant[1] & dec_i[1].pipe0_only;
	assign pipe_of[0] = revert;
	assign pipe_of[1] = ~revert;

	always_comb begin
		slot_o = '0;
		for (int k = 0; k < 2; k++) begin
			if (grant[k]) begin
				slot_o[pipe_of[k]].valid = 1'b1;
				slot_o[pipe_of[k]].inst = dec_i[k];
				slot_o[pipe_of[k]].fwd[0] = fwd_of(sb_q[dec_i[k].r_reg[0]]);
				slot_o[pipe_of[k]].fwd[1] = fwd_of(sb_q[dec_i[k].r_reg[1]]);
			end
		end
	end

	function automatic sb_entry_t sb_next(input sb_entry_t e, input logic [4:0] idx);
		sb_entry_t n;
		n = e;
		if (!stall_i) begin
			n.pos = {e.pos[1:0], 1'b0};
			n.rdy = {1'b0, e.rdy[2:1]};
		end
		// a fresh grant wins over the shift
		for (int k = 0; k < 2; k++) begin
			if (grant[k] && (dec_i[k].w_reg == idx)) begin
				n.pipe = pipe_of[k];
				n.pos = 3'b001;
				n.rdy = dec_i[k].slow ? 3'b100 : 3'b111;
			end
		end
		return n;
	endfunction

	// entry 0 is never written, r0 has no producer
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sb_q <= '0;
		end else begin
			for (int e = 1; e < 32; e++) begin
				sb_q[e] <= sb_next(sb_q[e], 5'(e));
			end
		end
	end

	a_in_order: assert property (@(posedge clk) disable iff (!rst_n)
		accept_o != 2'b10);

	a_stall_blocks: assert property (@(posedge clk) disable iff (!rst_n)
		stall_i |-> accept_o == 2'b00);

endmodule

`default_nettype wire

/* regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile import core_pkg::*; #(
	parameter int DATA_W = 32
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [3:0][4:0]        raddr_i,
	output logic [3:0][DATA_W-1:0] rdata_o,
	input  wb_ctrl_t [1:0]         wb_ctrl_i,
	input  logic [1:0][DATA_W-1:0] wb_data_i
);

	logic [DATA_W-1:0] mem [32];

	always_ff @(posedge clk) begin
		for (int p = 0; p < 2; p++) begin
			if (wb_ctrl_i[p].valid && (wb_ctrl_i[p].w_reg != 5'd0)) begin
				mem[wb_ctrl_i[p].w_reg] <= wb_data_i[p];
			end
		end
	end

	// write-first: a same-cycle writeback overrides the stored word
	always_comb begin
		for (int r = 0; r < 4; r++) begin
			rdata_o[r] = mem[raddr_i[r]];
			for (int p = 0; p < 2; p++) begin
				if (wb_ctrl_i[p].valid && (wb_ctrl_i[p].w_reg == raddr_i[r])) begin
					rdata_o[r] = wb_data_i[p];
				end
			end
			if (raddr_i[r] == 5'd0) begin
				rdata_o[r] = '0;
			end
		end
	end

	// pair checks at issue keep both pipes off the same register
	a_one_writer: assert property (@(posedge clk) disable iff (!rst_n)
		wb_ctrl_i[0].valid && wb_ctrl_i[1].valid |-> wb_ctrl_i[0].w_reg != wb_ctrl_i[1].w_reg);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and decide on the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_backend -f files.f -o tb_backend_sim \
	&& ./obj_dir/tb_backend_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TESTBENCH PASSED" sim.log 2>/dev/null && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* tb_backend.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_backend import core_pkg::*; ();

	localparam int DATA_W = 32;
	localparam int N_INST = 2000;
	localparam int CLK_PERIOD = 10;
	localparam int TIMEOUT_NS = N_INST * 10 * CLK_PERIOD;

	logic clk;
	logic rst_n;
	logic [1:0][31:0] inst_word;
	logic [1:0] inst_valid;
	logic stall;
	logic [1:0] accept;
	wb_ctrl_t [1:0] wb_ctrl;
	logic [1:0][DATA_W-1:0] wb_data;
	int err_cnt;
	int pending;

	logic [31:0] lcg_state = 32'h6516;
	int gen_cnt = 0;

	backend_top #(.DATA_W(DATA_W)) uut (
		.clk          (clk),
		.rst_n        (rst_n),
		.inst_word_i  (inst_word),
		.inst_valid_i (inst_valid),
		.stall_i      (stall),
		.accept_o     (accept),
		.wb_ctrl_o    (wb_ctrl),
		.wb_data_o    (wb_data)
	);

	tb_checker #(.DATA_W(DATA_W)) u_chk (
		.clk          (clk),
		.rst_n        (rst_n),
		.inst_word_i  (inst_word),
		.inst_valid_i (inst_valid),
		.stall_i      (stall),
		.accept_o     (accept),
		.wb_ctrl_o    (wb_ctrl),
		.wb_data_o    (wb_data),
		.err_cnt_o    (err_cnt),
		.pending_o    (pending)
	);

	function automatic logic [31:0] rand_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// registers r0..r7 only, so dependencies are frequent
	function automatic logic [31:0] make_inst();
		logic [31:0] r;
		logic [31:0] word;
		int sel;
		r = rand_next();
		word = rand_next();
		sel = int'(r[31:16] % 16'd6);
		case (sel)
			0: word[31:26] = OP_MUL;
			1: word[31:26] = OP_ADD;
			2: word[31:26] = OP_SUB;
			3: word[31:26] = OP_AND;
			4: word[31:26] = OP_XOR;
			default: word[31:26] = OP_ADDI;
		endcase
		// now and then an unknown opcode, which decodes as nop
		if (r[15:11] == 5'd0) begin
			word[31:26] = 6'h3f;
		end
		word[4:0] = {2'b00, r[2:0]};
		word[9:5] = {2'b00, r[5:3]};
		if (word[31:26] != OP_ADDI) begin
			word[14:10] = {2'b00, r[8:6]};
		end
		// first load r1..r7 from r0 so no register is read before written
		if (gen_cnt < 7) begin
			word = {OP_ADDI, word[25:10], 5'd0, 5'(gen_cnt + 1)};
		end
		gen_cnt++;
		return word;
	endfunction

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		logic [1:0][31:0] w;
		logic [1:0] v;
		logic [31:0] r;
		int n_acc;
		n_acc = 0;
		rst_n = 1'b0;
		inst_word = '0;
		inst_valid = 2'b00;
		stall = 1'b0;
		repeat (2) @(posedge clk);
		w[0] = make_inst();
		w[1] = make_inst();
		v = 2'b11;
		rst_n <= 1'b1;
		inst_word <= w;
		inst_valid <= v;
		while (n_acc < N_INST) begin
			@(posedge clk);
			n_acc += int'(accept[0]) + int'(accept[1]);
			if (accept == 2'b11) begin
				w[0] = make_inst();
				w[1] = make_inst();
			end else if (accept == 2'b01) begin
				// older word granted, the younger one moves up
				w[0] = w[1];
				w[1] = make_inst();
			end
			if (n_acc >= N_INST) begin
				v = 2'b00;
			end
			r = rand_next();
			inst_word <= w;
			inst_valid <= v;
			stall <= (r[18:16] == 3'd0);
		end
		// drain the pipes, stalls keep coming
		while (pending != 0) begin
			@(posedge clk);
			r = rand_next();
			stall <= (r[18:16] == 3'd0);
		end
		stall <= 1'b0;
		repeat (5) @(posedge clk);
		$display("run complete: %0d accepted, %0d pending, %0d errors", n_acc, pending, err_cnt);
		if ((err_cnt == 0) && (pending == 0)) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_checker import core_pkg::*; #(
	parameter int DATA_W = 32
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [1:0][31:0]       inst_word_i,
	input  logic [1:0]             inst_valid_i,
	input  logic                   stall_i,
	input  logic [1:0]             accept_o,
	input  wb_ctrl_t [1:0]         wb_ctrl_o,
	input  logic [1:0][DATA_W-1:0] wb_data_o,
	output int                     err_cnt_o,
	output int                     pending_o
);

	// one expected retirement, w_reg 0 means no write
	typedef struct packed {
		logic [4:0]        w_reg;
		logic [DATA_W-1:0] data;
		logic [31:0]       due;
	} exp_t;

	logic [DATA_W-1:0] model_rf [32];
	exp_t exp_q [$];
	// counts unstalled cycles only
	logic [31:0] ucnt;

	function automatic logic [5:0] op_of(input logic [31:0] w);
		case (w[31:26])
			OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI, OP_MUL: return w[31:26];
			default: return OP_NOP;
		endcase
	endfunction

	function automatic logic [4:0] dest_of(input logic [31:0] w);
		return (op_of(w) == OP_NOP) ? 5'd0 : w[4:0];
	endfunction

	function automatic logic reads_rk(input logic [5:0] op);
		return (op != OP_NOP) && (op != OP_ADDI);
	endfunction

	// rd = rj op rk, or rd = rj + sign-extended imm
	function automatic logic [DATA_W-1:0] model_value(input logic [5:0] op,
		input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b, input logic [11:0] imm);
		case (op)
			OP_ADD: return a + b;
			OP_SUB: return a - b;
			OP_AND: return a & b;
			OP_XOR: return a ^ b;
			OP_ADDI: return a + DATA_W'($signed(imm));
			OP_MUL: return a * b;
			default: return '0;
		endcase
	endfunction

	task automatic check_handshake();
		logic [31:0] w1;
		logic [4:0] w0_reg;
		logic [5:0] op1;
		w1 = inst_word_i[1];
		w0_reg = dest_of(inst_word_i[0]);
		op1 = op_of(w1);
		if (accept_o == 2'b10) begin
			$display("ERR %0t: accept_o is 10, slot 1 granted without slot 0", $time);
			err_cnt_o++;
		end
		if ((accept_o & ~inst_valid_i) != 2'b00) begin
			$display("ERR %0t: grant on a slot that is not valid", $time);
			err_cnt_o++;
		end
		if (stall_i && ((accept_o != 2'b00) || wb_ctrl_o[0].valid || wb_ctrl_o[1].valid)) begin
			$display("ERR %0t: grant or writeback while stalled", $time);
			err_cnt_o++;
		end
		if (accept_o == 2'b11) begin
			if ((w0_reg != 5'd0) && ((w0_reg == w1[9:5]) && (op1 != OP_NOP) ||
				(w0_reg == w1[14:10]) && reads_rk(op1) || (w0_reg == dest_of(w1)))) begin
				$display("ERR %0t: pair granted although slot 1 touches r%0d", $time, w0_reg);
				err_cnt_o++;
			end
			if ((op_of(inst_word_i[0]) == OP_MUL) && (op1 == OP_MUL)) begin
				$display("ERR %0t: two MUL instructions granted together", $time);
				err_cnt_o++;
			end
		end
	endtask

	task automatic match_writebacks();
		exp_t due_q [$];
		logic [1:0] used;
		logic hit;
		used = 2'b00;
		while ((exp_q.size() > 0) && (exp_q[0].due == ucnt)) begin
			due_q.push_back(exp_q.pop_front());
		end
		for (int p = 0; p < 2; p++) begin
			if (wb_ctrl_o[p].valid) begin
				hit = 1'b0;
				for (int i = 0; i < due_q.size(); i++) begin
					if (!hit && !used[i] && (due_q[i].w_reg != 5'd0) &&
						(due_q[i].w_reg == wb_ctrl_o[p].w_reg)) begin
						hit = 1'b1;
						used[i] = 1'b1;
						if (wb_data_o[p] !== due_q[i].data) begin
							$display("ERR %0t: r%0d written with %h, expected %h", $time,
								due_q[i].w_reg, wb_data_o[p], due_q[i].data);
							err_cnt_o++;
						end
					end
				end
				if (!hit) begin
					$display("ERR %0t: unexpected writeback to r%0d on pipe %0d", $time,
						wb_ctrl_o[p].w_reg, p);
					err_cnt_o++;
				end
			end
		end
		for (int i = 0; i < due_q.size(); i++) begin
			if ((due_q[i].w_reg != 5'd0) && !used[i]) begin
				$display("ERR %0t: missing writeback to r%0d", $time, due_q[i].w_reg);
				err_cnt_o++;
			end
		end
	endtask

	// in-order execution of the granted words, slot 0 first
	task automatic run_model();
		exp_t e;
		logic [31:0] w;
		for (int k = 0; k < 2; k++) begin
			if (accept_o[k]) begin
				w = inst_word_i[k];
				e.w_reg = dest_of(w);
				e.data = model_value(op_of(w), model_rf[w[9:5]], model_rf[w[14:10]], w[21:10]);
				e.due = ucnt + 32'd3;
				if (e.w_reg != 5'd0) begin
					model_rf[e.w_reg] = e.data;
				end
				exp_q.push_back(e);
			end
		end
	endtask

	// sampled mid-cycle, after all edge updates have settled
	always @(negedge clk) begin
		if (!rst_n) begin
			for (int r = 0; r < 32; r++) begin
				model_rf[r] = '0;
			end
			exp_q.delete();
			ucnt = '0;
			err_cnt_o = 0;
		end else begin
			check_handshake();
			if (!stall_i) begin
				match_writebacks();
				run_model();
				ucnt = ucnt + 32'd1;
			end
		end
		pending_o = exp_q.size();
	end

endmodule

`default_nettype wire
